// File: src/mul_pkg.sv
`default_nettype none

package mul_pkg;

	// ********************
	// widths
	// ********************

	// operand width of the core
	localparam int MUL_XLEN = 64;
	// low word used by mulw and friends
	localparam int MUL_WORD = 32;
	// one extension bit plus rounding up to an even width for radix-4
	localparam int MUL_EXT = 66;
	// partial product carries one more bit for the doubled multiplicand
	localparam int MUL_PP = MUL_EXT + 1;
	// full product of two extended operands
	localparam int MUL_PROD = 2 * MUL_EXT;

	// one booth digit per bit pair
	localparam int MUL_ITERS_D = 33;
	localparam int MUL_ITERS_W = 17;
	localparam int MUL_CNT_W = 6;

	// ********************
	// bundles
	// ********************

	typedef struct packed {
		logic                mulw;
		logic [1:0]          mul_signed;
		logic [MUL_XLEN-1:0] multiplicand;
		logic [MUL_XLEN-1:0] multiplier;
	} mul_req_t;

	typedef struct packed {
		logic [MUL_XLEN-1:0] result_hi;
		logic [MUL_XLEN-1:0] result_lo;
	} mul_res_t;

	// ********************
	// encodings
	// ********************

	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_LOAD,
		MUL_BUSY,
		MUL_DONE
	} mul_state_e;

	typedef enum logic [2:0] {
		BOOTH_ZERO,
		BOOTH_POS1,
		BOOTH_POS2,
		BOOTH_NEG1,
		BOOTH_NEG2
	} booth_sel_e;

endpackage

`default_nettype wire

// File: src/booth_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module booth_encoder import mul_pkg::*; (
	input  wire logic [2:0]         window,
	input  wire logic [MUL_EXT-1:0] cand,
	output logic      [MUL_PP-1:0]  pp
);

	booth_sel_e sel;

	// multiplicand and its double, both at partial product width
	logic [MUL_PP-1:0] cand_x1;
	logic [MUL_PP-1:0] cand_x2;

	// ********************
	// digit recoding
	// ********************

	// window is {b[i+1], b[i], b[i-1]}
	always_comb begin
		case (window)
			3'b000: sel = BOOTH_ZERO;
			3'b001: sel = BOOTH_POS1;
			3'b010: sel = BOOTH_POS1;
			3'b011: sel = BOOTH_POS2;
			3'b100: sel = BOOTH_NEG2;
			3'b101: sel = BOOTH_NEG1;
			3'b110: sel = BOOTH_NEG1;
			default: sel = BOOTH_ZERO;
		endcase
	end

	// ********************
	// partial product
	// ********************

	// sign bit copied up one place
	assign cand_x1 = {cand[MUL_EXT-1], cand};
	// shift left by one, no overflow since bits 65 and 64 always match
	assign cand_x2 = {cand, 1'b0};

	always_comb begin
		case (sel)
			BOOTH_POS1: pp = cand_x1;
			BOOTH_POS2: pp = cand_x2;
			// two's complement negatives
			BOOTH_NEG1: pp = ~cand_x1 + 1'b1;
			BOOTH_NEG2: pp = ~cand_x2 + 1'b1;
			default:    pp = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/mul_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mul_operand_stage import mul_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire mul_req_t             req,
	input  wire logic                 accept,
	input  wire logic [MUL_PROD-1:0]  product,
	output logic      [MUL_EXT-1:0]   ext_cand,
	output logic      [MUL_EXT-1:0]   ext_plier,
	output logic      [MUL_CNT_W-1:0] iter_count,
	output mul_res_t                  res
);

	// word mode flag kept for result formatting
	logic mulw_q;

	// narrow to the low word if needed, then sign or zero extend
	function automatic logic [MUL_EXT-1:0] extend_op(
		input logic [MUL_XLEN-1:0] op,
		input logic                word,
		input logic                sgn
	);
		logic msb;
		logic [MUL_EXT-1:0] ext;
		if (word) begin
			msb = sgn & op[MUL_WORD-1];
			ext = {{(MUL_EXT-MUL_WORD){msb}}, op[MUL_WORD-1:0]};
		end else begin
			msb = sgn & op[MUL_XLEN-1];
			ext = {{(MUL_EXT-MUL_XLEN){msb}}, op};
		end
		return ext;
	endfunction

	// ********************
	// request latch
	// ********************

	// operands only change on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			// bit 1 for the multiplicand, bit 0 for the multiplier
			ext_cand  <= extend_op(req.multiplicand, req.mulw, req.mul_signed[1]);
			ext_plier <= extend_op(req.multiplier, req.mulw, req.mul_signed[0]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mulw_q     <= 1'b0;
			iter_count <= MUL_CNT_W'(MUL_ITERS_D);
		end else if (accept) begin
			mulw_q     <= req.mulw;
			// word operands need only 34 bits of multiplier
			iter_count <= req.mulw ? MUL_CNT_W'(MUL_ITERS_W) : MUL_CNT_W'(MUL_ITERS_D);
		end
	end

	// ********************
	// result formatting
	// ********************

	always_comb begin
		if (mulw_q) begin
			// low word sign-extended, upper half unused
			res.result_hi = '0;
			res.result_lo = {{(MUL_XLEN-MUL_WORD){product[MUL_WORD-1]}}, product[MUL_WORD-1:0]};
		end else begin
			res.result_hi = product[2*MUL_XLEN-1:MUL_XLEN];
			res.result_lo = product[MUL_XLEN-1:0];
		end
	end

endmodule

`default_nettype wire

// File: src/booth_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module booth_multiplier import mul_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 mul_valid,
	input  wire logic                 flush,
	input  wire logic [MUL_EXT-1:0]   ext_cand,
	input  wire logic [MUL_EXT-1:0]   ext_plier,
	input  wire logic [MUL_CNT_W-1:0] iter_count,
	output logic                      accept,
	output logic                      mul_ready,
	output logic                      out_valid,
	output logic      [MUL_PROD-1:0]  product
);

	// shift amount for the current bit pair
	localparam int WEIGHT_W = $clog2(MUL_PROD);

	// ********************
	// declarations
	// ********************

	mul_state_e state;
	mul_state_e state_nxt;

	// iterations left in MUL_BUSY
	logic [MUL_CNT_W-1:0] cnt;

	// multiplier with implicit zero below bit 0
	logic [MUL_EXT:0] plier_sr;

	// running sum of aligned partial products
	logic [MUL_PROD-1:0] acc;
	logic [WEIGHT_W-1:0] weight;

	// encoder output and its aligned copy
	logic [MUL_PP-1:0]   pp;
	logic [MUL_PROD-1:0] pp_wide;
	logic [MUL_PROD-1:0] pp_aligned;

	// last busy cycle
	logic last_iter;

	// ********************
	// handshake
	// ********************

	// only take new work when idle
	assign mul_ready = (state == MUL_IDLE);

	// flush in idle blocks the request
	assign accept = mul_ready & mul_valid & ~flush;

	// single cycle strobe
	assign out_valid = (state == MUL_DONE);

	assign last_iter = (cnt == MUL_CNT_W'(1));

	// ********************
	// state machine
	// ********************

	always_comb begin
		state_nxt = state;
		case (state)
			MUL_IDLE: begin
				if (accept) begin
					state_nxt = MUL_LOAD;
				end
			end
			MUL_LOAD: begin
				// operands are in the stage registers now
				state_nxt = flush ? MUL_IDLE : MUL_BUSY;
			end
			MUL_BUSY: begin
				if (flush) begin
					state_nxt = MUL_IDLE;
				end else if (last_iter) begin
					state_nxt = MUL_DONE;
				end
			end
			MUL_DONE: begin
				// back to idle whether or not flush is up
				state_nxt = MUL_IDLE;
			end
			default: begin
				state_nxt = MUL_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MUL_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// down-counter, fixed latency per mode
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (state == MUL_LOAD) begin
			cnt <= iter_count;
		end else if (state == MUL_BUSY) begin
			cnt <= cnt - 1'b1;
		end
	end

	// ********************
	// booth datapath
	// ********************

	// low three bits form the current window
	booth_encoder booth_encoder_inst (
		.window (plier_sr[2:0]),
		.cand   (ext_cand),
		.pp     (pp)
	);

	// sign extend to product width before shifting
	assign pp_wide = {{(MUL_PROD-MUL_PP){pp[MUL_PP-1]}}, pp};

	// place at bit 2*i
	assign pp_aligned = pp_wide << weight;

	always_ff @(posedge clk) begin
		case (state)
			MUL_LOAD: begin
				acc      <= '0;
				plier_sr <= {ext_plier, 1'b0};
				weight   <= '0;
			end
			MUL_BUSY: begin
				acc <= acc + pp_aligned;
				// arithmetic shift so upper windows keep the sign
				plier_sr <= {{2{plier_sr[MUL_EXT]}}, plier_sr[MUL_EXT:2]};
				weight   <= weight + WEIGHT_W'(2);
			end
			default: begin
				// hold the product after done
				acc      <= acc;
				plier_sr <= plier_sr;
				weight   <= weight;
			end
		endcase
	end

	// raw product, formatted by the operand stage
	assign product = acc;

endmodule

`default_nettype wire

// File: src/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit import mul_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     mul_valid,
	input  wire logic     flush,
	input  wire mul_req_t req,
	output logic          mul_ready,
	output logic          out_valid,
	output mul_res_t      res
);

	// ********************
	// internal wiring
	// ********************

	// request taken this cycle
	logic accept;

	// latched and extended operands
	logic [MUL_EXT-1:0]   ext_cand;
	logic [MUL_EXT-1:0]   ext_plier;
	logic [MUL_CNT_W-1:0] iter_count;

	// raw booth sum
	logic [MUL_PROD-1:0] product;

	// latches the request and shapes the result
	mul_operand_stage mul_operand_stage_inst (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.accept     (accept),
		.product    (product),
		.ext_cand   (ext_cand),
		.ext_plier  (ext_plier),
		.iter_count (iter_count),
		.res        (res)
	);

	// iterative radix-4 core
	booth_multiplier booth_multiplier_inst (
		.clk        (clk),
		.rst        (rst),
		.mul_valid  (mul_valid),
		.flush      (flush),
		.ext_cand   (ext_cand),
		.ext_plier  (ext_plier),
		.iter_count (iter_count),
		.accept     (accept),
		.mul_ready  (mul_ready),
		.out_valid  (out_valid),
		.product    (product)
	);

endmodule

`default_nettype wire

// File: test/mul_model.svh
`ifndef MUL_MODEL_SVH
`define MUL_MODEL_SVH

// ********************
// reference model
// ********************

// expected result from a plain wide multiply of the extended operands
function automatic mul_res_t model_product(input mul_req_t r);
	logic [127:0] a_full;
	logic [127:0] b_full;
	logic [127:0] p_full;
	logic [63:0]  a_word;
	logic [63:0]  b_word;
	logic [63:0]  p_word;
	mul_res_t     expected;
	expected = '0;
	if (r.mulw) begin
		// low words only, each extended by its own signed flag
		a_word = {{32{r.mul_signed[1] & r.multiplicand[31]}}, r.multiplicand[31:0]};
		b_word = {{32{r.mul_signed[0] & r.multiplier[31]}}, r.multiplier[31:0]};
		p_word = a_word * b_word;
		// low word of the product, sign-extended
		expected.result_hi = '0;
		expected.result_lo = {{32{p_word[31]}}, p_word[31:0]};
	end else begin
		// 128 bit extension keeps every mixed-sign case exact modulo 2^128
		a_full = {{64{r.mul_signed[1] & r.multiplicand[63]}}, r.multiplicand};
		b_full = {{64{r.mul_signed[0] & r.multiplier[63]}}, r.multiplier};
		p_full = a_full * b_full;
		expected.result_hi = p_full[127:64];
		expected.result_lo = p_full[63:0];
	end
	return expected;
endfunction

`endif

// File: test/tb_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mul_unit import mul_pkg::*; ();

	// ********************
	// run length
	// ********************

	localparam int N_FULL = 160;
	localparam int N_WORD = 120;
	// each flush test also sends one clean request
	localparam int N_FLUSH = 40;
	localparam int LAT_FULL = 35;
	localparam int LAT_WORD = 19;
	localparam int WAIT_LIMIT = 60;
	// 400 requests at 40 cycles plus margin for reset and idle phases
	localparam int CYCLE_LIMIT = 400 * 40 + 2000;

	logic     clk;
	logic     rst;
	logic     mul_valid;
	logic     flush;
	mul_req_t req;
	logic     mul_ready;
	logic     out_valid;
	mul_res_t res;

	int errors;
	int cycle_count;

	`include "mul_model.svh"

	mul_unit mul_unit_inst (
		.clk       (clk),
		.rst       (rst),
		.mul_valid (mul_valid),
		.flush     (flush),
		.req       (req),
		.mul_ready (mul_ready),
		.out_valid (out_valid),
		.res       (res)
	);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ********************
	// watchdog
	// ********************

	initial begin
		cycle_count = 0;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test FAILED");
		$finish;
	end

	// ********************
	// helpers
	// ********************

	// step to 1 ns past the next rising edge where outputs have settled
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		if (got !== expected) begin
			$display("** Error at %0t: %s got %0h expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	// edge values mixed in with plain random words
	function automatic logic [63:0] random_operand();
		int unsigned pick;
		pick = $urandom_range(9, 0);
		case (pick)
			0: return 64'h0;
			1: return {64{1'b1}};
			2: return 64'h8000_0000_0000_0000;
			// word mode edges
			3: return {$urandom, 32'h8000_0000};
			4: return {$urandom, 32'hffff_ffff};
			default: return {$urandom, $urandom};
		endcase
	endfunction

	function automatic mul_req_t random_request(input logic mulw, input logic [1:0] sgn);
		mul_req_t r;
		r.mulw = mulw;
		r.mul_signed = sgn;
		r.multiplicand = random_operand();
		r.multiplier = random_operand();
		return r;
	endfunction

	// waits for ready and then holds mul_valid over one edge
	task automatic issue_request(input mul_req_t r);
		int waited;
		waited = 0;
		while (!mul_ready && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (!mul_ready) begin
			$display("mul_ready never came back high at %0t", $time);
			errors++;
		end
		mul_valid = 1'b1;
		req = r;
		tick();
		mul_valid = 1'b0;
		// scramble so a missing latch shows up as a wrong result
		req = random_request(1'($urandom), 2'($urandom));
	endtask

	task automatic run_request(input mul_req_t r);
		mul_res_t expected;
		int       edges;
		int       lat;
		expected = model_product(r);
		lat = r.mulw ? LAT_WORD : LAT_FULL;
		issue_request(r);
		// accepting edge counts as the first
		edges = 1;
		while (!out_valid && edges < WAIT_LIMIT) begin
			check_value("mul_ready", 128'(mul_ready), 128'd0);
			tick();
			edges++;
		end
		if (!out_valid) begin
			$display("no out_valid within %0d cycles of accept at %0t", WAIT_LIMIT, $time);
			errors++;
		end else begin
			check_value("latency", 128'(edges), 128'(lat));
			check_value("mul_ready", 128'(mul_ready), 128'd0);
			check_value("result_hi", 128'(res.result_hi), 128'(expected.result_hi));
			check_value("result_lo", 128'(res.result_lo), 128'(expected.result_lo));
			tick();
			// out_valid lasts one cycle and res holds until the next accept
			check_value("out_valid", 128'(out_valid), 128'd0);
			check_value("mul_ready", 128'(mul_ready), 128'd1);
			check_value("res", 128'(res), 128'(expected));
		end
	endtask

	// abort somewhere in load or busy and confirm recovery
	task automatic flush_request(input mul_req_t r);
		int lat;
		int hold;
		lat = r.mulw ? LAT_WORD : LAT_FULL;
		hold = $urandom_range(lat - 2, 0);
		issue_request(r);
		repeat (hold) begin
			check_value("out_valid", 128'(out_valid), 128'd0);
			tick();
		end
		flush = 1'b1;
		tick();
		flush = 1'b0;
		check_value("mul_ready", 128'(mul_ready), 128'd1);
		// no late strobe from the aborted op
		repeat (LAT_FULL + 5) begin
			check_value("out_valid", 128'(out_valid), 128'd0);
			check_value("mul_ready", 128'(mul_ready), 128'd1);
			tick();
		end
		run_request(random_request(1'($urandom), 2'($urandom)));
	endtask

	// mul_valid up but flush blocks acceptance
	task automatic idle_flush();
		mul_valid = 1'b1;
		flush = 1'b1;
		req = random_request(1'($urandom), 2'($urandom));
		repeat (20) begin
			tick();
			check_value("mul_ready", 128'(mul_ready), 128'd1);
			check_value("out_valid", 128'(out_valid), 128'd0);
		end
		mul_valid = 1'b0;
		flush = 1'b0;
		tick();
		check_value("mul_ready", 128'(mul_ready), 128'd1);
	endtask

	// ********************
	// main sequence
	// ********************

	initial begin
		errors = 0;
		void'($urandom(66090));
		rst = 1'b1;
		mul_valid = 1'b0;
		flush = 1'b0;
		req = '0;
		repeat (10) tick();
		rst = 1'b0;
		tick();

		// reset state
		check_value("mul_ready", 128'(mul_ready), 128'd1);
		check_value("out_valid", 128'(out_valid), 128'd0);

		// full mode cycling through all signedness codes
		for (int i = 0; i < N_FULL; i++) begin
			run_request(random_request(1'b0, 2'(i)));
		end

		// word mode
		for (int i = 0; i < N_WORD; i++) begin
			run_request(random_request(1'b1, 2'(i)));
		end

		for (int i = 0; i < N_FLUSH; i++) begin
			flush_request(random_request(1'($urandom), 2'($urandom)));
		end

		idle_flush();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+test
src/mul_pkg.sv
src/booth_encoder.sv
src/mul_operand_stage.sv
src/booth_multiplier.sv
src/mul_unit.sv
test/tb_mul_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the multiply unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_tb_mul_unit

verilator --binary --timing -Wno-fatal \
	-f filelist.f \
	--top-module tb_mul_unit \
	-Mdir "$build_dir" \
	-o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$("./$build_dir/$sim_bin" 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
